//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_vector_sequencer
FILELIST  ?= list.f

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST))
LOG     := sim.log

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) test/sequencer_patterns.txt
	./$(SIM) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- list.f
verilog/seq_pkg.sv
verilog/vinsn_tracker.sv
verilog/vreg_scoreboard.sv
verilog/insn_queue_counter.sv
verilog/issue_ctrl.sv
verilog/vector_sequencer.sv
test/seq_checker.sv
test/tb_vector_sequencer.sv

//--- test/seq_checker.sv
// Sequencer checker mirroring running IDs, register lists and queue counts from the ports
`timescale 1ns/1ps
`default_nettype none

module seq_checker import seq_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     req_valid_i,
  input  wire logic                     req_ready_o,
  input  wire unit_t                    req_unit_i,
  input  wire vreg_t                    req_vs1_i,
  input  wire logic                     req_use_vs1_i,
  input  wire vreg_t                    req_vs2_i,
  input  wire logic                     req_use_vs2_i,
  input  wire vreg_t                    req_vd_i,
  input  wire logic                     req_use_vd_i,
  input  wire logic                     req_vm_i,
  input  wire logic                     issue_valid_o,
  input  wire logic                     issue_ready_i,
  input  wire vid_t                     issue_id_o,
  input  wire unit_t                    issue_unit_o,
  input  wire vreg_t                    issue_vs1_o,
  input  wire logic                     issue_use_vs1_o,
  input  wire vreg_t                    issue_vs2_o,
  input  wire logic                     issue_use_vs2_o,
  input  wire vreg_t                    issue_vd_o,
  input  wire logic                     issue_use_vd_o,
  input  wire logic                     issue_vm_o,
  input  wire vid_mask_t                hazard_vs1_o,
  input  wire vid_mask_t                hazard_vs2_o,
  input  wire vid_mask_t                hazard_vm_o,
  input  wire vid_mask_t                hazard_vd_o,
  input  wire vid_mask_t [nr_units-1:0] unit_done_i,
  input  wire logic                     idle_o,
  input  wire vid_mask_t                running_o,
  output logic [31:0]                   errors_o,
  output logic [31:0]                   accepts_o
);

  string fname [13] = '{"id", "unit", "vs1", "use_vs1", "vs2", "use_vs2", "vd", "use_vd",
                        "vm", "hazard_vs1", "hazard_vs2", "hazard_vm", "hazard_vd"};

  // Mirrored state
  vid_mask_t   run_u [nr_units];
  int unsigned cnt_m [nr_units];
  int          rd_id [nr_vregs];
  int          wr_id [nr_vregs];
  bit          rd_v  [nr_vregs];
  bit          wr_v  [nr_vregs];
  logic        iv_m;
  logic [31:0] exp_f [13];

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
      errors_o++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sample at the falling edge, where ports are settled
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    vid_mask_t   run_m;
    vid_mask_t   hz [4];
    logic [31:0] act_f [13];
    logic [31:0] new_f [13];
    logic        stall;
    logic        exp_ready;
    logic        accept;
    int          id;
    if (!rst_ni) begin
      for (int u = 0; u < nr_units; u++) begin
        run_u[u] = '0;
        cnt_m[u] = 0;
      end
      for (int r = 0; r < nr_vregs; r++) begin
        rd_v[r] = 1'b0;
        wr_v[r] = 1'b0;
      end
      iv_m      = 1'b0;
      errors_o  = 0;
      accepts_o = 0;
    end else begin
      run_m = '0;
      for (int u = 0; u < nr_units; u++) run_m |= run_u[u];
      compare("idle", 32'(run_m == '0), 32'(idle_o));
      compare("running", 32'(run_m), 32'(running_o));
      // Front-end readiness from stall, free IDs and unit room
      stall     = iv_m & ~issue_ready_i;
      exp_ready = !stall && (run_m != '1) && (cnt_m[req_unit_i] < unit_depth[req_unit_i]);
      if (req_valid_i) compare("req_ready", 32'(exp_ready), 32'(req_ready_o));
      // Held issue must match, which also covers stability under stall
      compare("issue_valid", 32'(iv_m), 32'(issue_valid_o));
      act_f = '{32'(issue_id_o), 32'(issue_unit_o), 32'(issue_vs1_o), 32'(issue_use_vs1_o),
                32'(issue_vs2_o), 32'(issue_use_vs2_o), 32'(issue_vd_o),
                32'(issue_use_vd_o), 32'(issue_vm_o), 32'(hazard_vs1_o),
                32'(hazard_vs2_o), 32'(hazard_vm_o), 32'(hazard_vd_o)};
      if (iv_m) begin
        for (int i = 0; i < 13; i++) begin
          compare($sformatf("accept %0d %s", accepts_o, fname[i]), exp_f[i], act_f[i]);
        end
      end
      accept = req_valid_i & exp_ready;
      // Lowest free ID and the hazards, from the lists before this update
      id = 0;
      for (int i = nr_vinsn - 1; i >= 0; i--) if (!run_m[i]) id = i;
      for (int k = 0; k < 4; k++) hz[k] = '0;
      if (req_use_vs1_i && wr_v[req_vs1_i]) hz[0][wr_id[req_vs1_i]] = 1'b1;
      if (req_use_vs2_i && wr_v[req_vs2_i]) hz[1][wr_id[req_vs2_i]] = 1'b1;
      if (!req_vm_i && wr_v[vmask_reg]) hz[2][wr_id[vmask_reg]] = 1'b1;
      if (req_use_vd_i && wr_v[req_vd_i]) hz[3][wr_id[req_vd_i]] = 1'b1;
      if (req_use_vd_i && rd_v[req_vd_i]) hz[3][rd_id[req_vd_i]] = 1'b1;
      // Done pulses retire IDs and every list entry they own
      for (int u = 0; u < nr_units; u++) begin
        if (unit_done_i[u] != '0) begin
          if ((unit_done_i[u] & ~run_u[u]) != '0 || $countones(unit_done_i[u]) > 1) begin
            $display("Done pulse on unit %0d names an ID not running there", u);
            errors_o++;
          end
          for (int r = 0; r < nr_vregs; r++) begin
            if (rd_v[r] && unit_done_i[u][rd_id[r]]) rd_v[r] = 1'b0;
            if (wr_v[r] && unit_done_i[u][wr_id[r]]) wr_v[r] = 1'b0;
          end
          run_u[u] &= ~unit_done_i[u];
          if (cnt_m[u] > 0) cnt_m[u]--;
        end
      end
      if (accept) begin
        new_f = '{32'(id), 32'(req_unit_i), 32'(req_vs1_i), 32'(req_use_vs1_i),
                  32'(req_vs2_i), 32'(req_use_vs2_i), 32'(req_vd_i), 32'(req_use_vd_i),
                  32'(req_vm_i), 32'(hz[0]), 32'(hz[1]), 32'(hz[2]), 32'(hz[3])};
        if (req_use_vd_i) begin
          wr_v[req_vd_i]  = 1'b1;
          wr_id[req_vd_i] = id;
        end
        if (req_use_vs1_i) begin
          rd_v[req_vs1_i]  = 1'b1;
          rd_id[req_vs1_i] = id;
        end
        if (req_use_vs2_i) begin
          rd_v[req_vs2_i]  = 1'b1;
          rd_id[req_vs2_i] = id;
        end
        if (!req_vm_i) begin
          rd_v[vmask_reg]  = 1'b1;
          rd_id[vmask_reg] = id;
        end
        run_u[req_unit_i][id] = 1'b1;
        cnt_m[req_unit_i]++;
        accepts_o++;
      end
      if (!stall) iv_m = accept;
      if (accept) exp_f = new_f;
    end
  end

endmodule

`default_nettype wire

//--- test/sequencer_patterns.txt
# R unit vs1 use_vs1 vs2 use_vs2 vd use_vd vm | D unit id | W cycles | H unit cycles
# Units 0 alu, 1 mfpu, 2 load, 3 store; all values decimal
R 2 0 0 0 0 1 1 1
R 2 0 0 0 0 2 1 1
H 2 6
R 0 1 1 2 1 3 1 1
R 1 3 1 1 1 0 1 1
R 0 4 0 5 0 1 1 0
D 2 0
W 2
R 2 0 0 0 0 6 1 1
D 2 1
D 0 2
R 3 3 1 0 0 0 0 0
R 3 1 1 0 0 0 0 1
H 3 4
D 3 1
D 3 2
R 0 6 1 0 0 7 1 1
R 0 7 1 7 1 7 1 1
R 0 0 0 0 0 6 1 1
H 0 5
D 0 4
D 0 1
D 0 2
D 0 5
D 1 3
D 2 0
W 3
R 0 1 1 0 0 7 1 1
D 0 0
W 10

//--- test/tb_vector_sequencer.sv
// Testbench for the vector sequencer that replays a command file against the DUT
`timescale 1ns/1ps
`default_nettype none

module tb_vector_sequencer import seq_pkg::*; ();

  localparam int max_cmds = 256;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     req_valid_i;
  logic                     req_ready_o;
  unit_t                    req_unit_i;
  vreg_t                    req_vs1_i;
  logic                     req_use_vs1_i;
  vreg_t                    req_vs2_i;
  logic                     req_use_vs2_i;
  vreg_t                    req_vd_i;
  logic                     req_use_vd_i;
  logic                     req_vm_i;
  logic                     issue_valid_o;
  logic                     issue_ready_i;
  vid_t                     issue_id_o;
  unit_t                    issue_unit_o;
  vreg_t                    issue_vs1_o;
  logic                     issue_use_vs1_o;
  vreg_t                    issue_vs2_o;
  logic                     issue_use_vs2_o;
  vreg_t                    issue_vd_o;
  logic                     issue_use_vd_o;
  logic                     issue_vm_o;
  vid_mask_t                hazard_vs1_o;
  vid_mask_t                hazard_vs2_o;
  vid_mask_t                hazard_vm_o;
  vid_mask_t                hazard_vd_o;
  vid_mask_t [nr_units-1:0] unit_done_i;
  logic                     idle_o;
  vid_mask_t                running_o;

  // Commands loaded from the pattern file
  byte         cmd_c [max_cmds];
  int          cmd_a [max_cmds][8];
  int          n_cmds;
  logic        loaded;
  int          n_requests;
  logic [31:0] check_errors;
  logic [31:0] accepts;

  vector_sequencer vector_sequencer_i (.*);

  seq_checker seq_checker_i (.*, .errors_o(check_errors), .accepts_o(accepts));

  ////////////////////////////////////////////////////////////
  // Clock and random back-pressure
  ////////////////////////////////////////////////////////////

  always #10 clk_i = ~clk_i;

  // Units take the issue about three times in four
  initial begin
    void'($urandom(32'h2f42_3f37));
    forever begin
      @(posedge clk_i);
      #2;
      issue_ready_i = (($urandom % 4) != 0);
    end
  end

  ////////////////////////////////////////////////////////////
  // Pattern file
  ////////////////////////////////////////////////////////////

  task automatic load_patterns();
    int    fd;
    int    a0, a1, a2, a3, a4, a5, a6, a7;
    string line;
    byte   c;
    fd = $fopen("test/sequencer_patterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file");
      return;
    end
    while (!$feof(fd) && n_cmds < max_cmds) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2) continue;
      c = line.getc(0);
      // Comment and blank lines carry no command
      if (c != "R" && c != "D" && c != "W" && c != "H") continue;
      {a0, a1, a2, a3, a4, a5, a6, a7} = '0;
      void'($sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d %d %d %d",
                    a0, a1, a2, a3, a4, a5, a6, a7));
      cmd_c[n_cmds] = c;
      cmd_a[n_cmds] = '{a0, a1, a2, a3, a4, a5, a6, a7};
      n_cmds++;
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers, each ending 2 ns after a rising edge
  ////////////////////////////////////////////////////////////

  // Holds the request until taken, or for at most max_cycles when that is positive
  task automatic drive_request(input int f[8], input int max_cycles);
    logic taken;
    int   n;
    req_valid_i   = 1'b1;
    req_unit_i    = unit_t'(f[0]);
    req_vs1_i     = vreg_t'(f[1]);
    req_use_vs1_i = f[2][0];
    req_vs2_i     = vreg_t'(f[3]);
    req_use_vs2_i = f[4][0];
    req_vd_i      = vreg_t'(f[5]);
    req_use_vd_i  = f[6][0];
    req_vm_i      = f[7][0];
    taken = 1'b0;
    n = 0;
    while (!taken && (max_cycles <= 0 || n < max_cycles)) begin
      @(negedge clk_i);
      taken = req_ready_o;
      @(posedge clk_i);
      #2;
      n++;
    end
    if (taken) n_requests++;
    req_valid_i = 1'b0;
  endtask

  task automatic pulse_done(input int unit, input int id);
    unit_done_i[unit][id] = 1'b1;
    @(posedge clk_i);
    #2;
    unit_done_i = '0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int f[8];
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    {req_unit_i, req_vs1_i, req_vs2_i, req_vd_i} = '0;
    {req_use_vs1_i, req_use_vs2_i, req_use_vd_i} = '0;
    req_vm_i      = 1'b1;
    issue_ready_i = 1'b1;
    unit_done_i   = '0;
    n_cmds        = 0;
    n_requests    = 0;
    loaded        = 1'b0;
    load_patterns();
    loaded = 1'b1;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int i = 0; i < n_cmds; i++) begin
      f = cmd_a[i];
      case (cmd_c[i])
        "R": drive_request(f, 0);
        // Request to a full unit, withdrawn after a few cycles
        "H": drive_request('{f[0], 0, 0, 0, 0, 0, 0, 1}, f[1]);
        "D": pulse_done(f[0], f[1]);
        default: begin
          repeat (f[0]) @(posedge clk_i);
          #2;
        end
      endcase
    end
    repeat (4) @(posedge clk_i);
    if (n_cmds == 0) $display("No commands were read from the pattern file");
    if (accepts != 32'(n_requests)) begin
      $display("Checker saw %0d accepts but the driver counted %0d", accepts, n_requests);
    end
    $display("Errors: %0d failed checks, %0d driver mismatches", check_errors,
             (accepts != 32'(n_requests) || n_cmds == 0) ? 1 : 0);
    if (check_errors == 0 && accepts == 32'(n_requests) && n_cmds != 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog sized from the pattern count
  initial begin
    wait (loaded);
    repeat ((n_cmds + 4) * 50) @(posedge clk_i);
    $display("Watchdog expired before the pattern file finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/insn_queue_counter.sv
// Queue counter tracking outstanding instructions of one functional unit
`timescale 1ns/1ps
`default_nettype none

module insn_queue_counter import seq_pkg::*; #(
  parameter int unsigned depth = 2
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic up_i,
  input  wire logic down_i,
  output logic      ready_o
);

  cnt_t cnt_q;

  // One in, one out leaves the count alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (up_i && !down_i) begin
      cnt_q <= cnt_q + cnt_t'(1);
    end else if (down_i && !up_i) begin
      cnt_q <= cnt_q - cnt_t'(1);
    end
  end

  // Room for one more
  assign ready_o = (cnt_q < cnt_t'(depth));

endmodule

`default_nettype wire

//--- verilog/issue_ctrl.sv
// Issue controller accepting requests and holding the registered issue under back-pressure
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl import seq_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Front end
  input  wire logic       req_valid_i,
  input  wire unit_t      req_unit_i,
  input  wire vreg_t      req_vs1_i,
  input  wire logic       req_use_vs1_i,
  input  wire vreg_t      req_vs2_i,
  input  wire logic       req_use_vs2_i,
  input  wire vreg_t      req_vd_i,
  input  wire logic       req_use_vd_i,
  input  wire logic       req_vm_i,
  output logic            req_ready_o,
  // From the scoreboard
  input  wire vid_mask_t  hazard_vs1_i,
  input  wire vid_mask_t  hazard_vs2_i,
  input  wire vid_mask_t  hazard_vm_i,
  input  wire vid_mask_t  hazard_vd_i,
  // From the tracker and the counters
  input  wire vid_t       next_id_i,
  input  wire logic       full_i,
  input  wire unit_mask_t unit_ready_i,
  output logic            accept_o,
  output unit_mask_t      cnt_up_o,
  // Issue side
  input  wire logic       issue_ready_i,
  output logic            issue_valid_o,
  output vid_t            issue_id_o,
  output unit_t           issue_unit_o,
  output vreg_t           issue_vs1_o,
  output logic            issue_use_vs1_o,
  output vreg_t           issue_vs2_o,
  output logic            issue_use_vs2_o,
  output vreg_t           issue_vd_o,
  output logic            issue_use_vd_o,
  output logic            issue_vm_o,
  output vid_mask_t       hazard_vs1_o,
  output vid_mask_t       hazard_vs2_o,
  output vid_mask_t       hazard_vm_o,
  output vid_mask_t       hazard_vd_o
);

  // Pending issue not yet taken by the units
  logic stall;

  assign stall = issue_valid_o & ~issue_ready_i;

  // Needs a free issue slot, a free ID and room in the target queue
  assign req_ready_o = ~stall & ~full_i & unit_ready_i[req_unit_i];
  assign accept_o    = req_valid_i & req_ready_o;

  // Target unit gets one more outstanding instruction
  assign cnt_up_o = accept_o ? (unit_mask_t'(1) << req_unit_i) : '0;

  ////////////////////////////////////////////////////////////
  // Issue register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else if (!stall) begin
      issue_valid_o <= accept_o;
    end
  end

  // Loads only on accept, and no accept happens while stalled
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      issue_id_o      <= next_id_i;
      issue_unit_o    <= req_unit_i;
      issue_vs1_o     <= req_vs1_i;
      issue_use_vs1_o <= req_use_vs1_i;
      issue_vs2_o     <= req_vs2_i;
      issue_use_vs2_o <= req_use_vs2_i;
      issue_vd_o      <= req_vd_i;
      issue_use_vd_o  <= req_use_vd_i;
      issue_vm_o      <= req_vm_i;
      hazard_vs1_o    <= hazard_vs1_i;
      hazard_vs2_o    <= hazard_vs2_i;
      hazard_vm_o     <= hazard_vm_i;
      hazard_vd_o     <= hazard_vd_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/seq_pkg.sv
// Sequencer package with the shared sizes, unit indices, queue depths and vector types
`default_nettype none

package seq_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Instruction IDs that can be in flight at once
  localparam int unsigned nr_vinsn = 8;
  // Architectural vector registers
  localparam int unsigned nr_vregs = 32;
  // Functional units fed by the sequencer
  localparam int unsigned nr_units = 4;

  // Unit indices, as carried on req_unit_i and issue_unit_o
  localparam int unsigned unit_alu   = 0;
  localparam int unsigned unit_mfpu  = 1;
  localparam int unsigned unit_load  = 2;
  localparam int unsigned unit_store = 3;

  // Masked instructions read their mask from v0
  localparam int unsigned vmask_reg = 0;

  // Instruction queue depth of each unit
  localparam int unsigned unit_depth [nr_units] = '{
    unit_alu:   4,
    unit_mfpu:  4,
    unit_load:  2,
    unit_store: 2
  };
  localparam int unsigned max_depth = 4;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [$clog2(nr_vinsn)-1:0]    vid_t;
  // One bit per instruction ID, for hazards and running sets
  typedef logic [nr_vinsn-1:0]            vid_mask_t;
  typedef logic [$clog2(nr_vregs)-1:0]    vreg_t;
  typedef logic [$clog2(nr_units)-1:0]    unit_t;
  typedef logic [nr_units-1:0]            unit_mask_t;
  // Queue occupancy, 0 up to and including max_depth
  typedef logic [$clog2(max_depth+1)-1:0] cnt_t;

endpackage

`default_nettype wire

//--- verilog/vector_sequencer.sv
// Vector instruction sequencer top with ID tracking, hazard scoreboard and unit queue counters
`timescale 1ns/1ps
`default_nettype none

module vector_sequencer import seq_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // Front end
  input  wire logic                     req_valid_i,
  output logic                          req_ready_o,
  input  wire unit_t                    req_unit_i,
  input  wire vreg_t                    req_vs1_i,
  input  wire logic                     req_use_vs1_i,
  input  wire vreg_t                    req_vs2_i,
  input  wire logic                     req_use_vs2_i,
  input  wire vreg_t                    req_vd_i,
  input  wire logic                     req_use_vd_i,
  input  wire logic                     req_vm_i,
  // Issue side
  output logic                          issue_valid_o,
  input  wire logic                     issue_ready_i,
  output vid_t                          issue_id_o,
  output unit_t                         issue_unit_o,
  output vreg_t                         issue_vs1_o,
  output logic                          issue_use_vs1_o,
  output vreg_t                         issue_vs2_o,
  output logic                          issue_use_vs2_o,
  output vreg_t                         issue_vd_o,
  output logic                          issue_use_vd_o,
  output logic                          issue_vm_o,
  output vid_mask_t                     hazard_vs1_o,
  output vid_mask_t                     hazard_vs2_o,
  output vid_mask_t                     hazard_vm_o,
  output vid_mask_t                     hazard_vd_o,
  // Completion and status
  input  wire vid_mask_t [nr_units-1:0] unit_done_i,
  output logic                          idle_o,
  output vid_mask_t                     running_o
);

  logic       accept;
  vid_t       next_id;
  logic       full;
  unit_mask_t unit_done_any;
  unit_mask_t unit_ready;
  unit_mask_t cnt_up;
  vid_mask_t  hz_vs1, hz_vs2, hz_vm, hz_vd;

  ////////////////////////////////////////////////////////////
  // ID bookkeeping and hazards
  ////////////////////////////////////////////////////////////

  vinsn_tracker vinsn_tracker_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .alloc_i         (accept),
    .alloc_unit_i    (req_unit_i),
    .unit_done_i     (unit_done_i),
    .next_id_o       (next_id),
    .full_o          (full),
    .running_o       (running_o),
    .unit_done_any_o (unit_done_any),
    .idle_o          (idle_o)
  );

  vreg_scoreboard vreg_scoreboard_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .new_id_i     (next_id),
    .running_i    (running_o),
    .vs1_i        (req_vs1_i),
    .vs2_i        (req_vs2_i),
    .vd_i         (req_vd_i),
    .use_vs1_i    (req_use_vs1_i),
    .use_vs2_i    (req_use_vs2_i),
    .use_vd_i     (req_use_vd_i),
    .vm_i         (req_vm_i),
    .hazard_vs1_o (hz_vs1),
    .hazard_vs2_o (hz_vs2),
    .hazard_vm_o  (hz_vm),
    .hazard_vd_o  (hz_vd)
  );

  ////////////////////////////////////////////////////////////
  // Per-unit queue counters
  ////////////////////////////////////////////////////////////

  // Up on accept, down on any done of that unit
  for (genvar u = 0; u < nr_units; u++) begin : gen_queue_cnt
    insn_queue_counter #(
      .depth (unit_depth[u])
    ) insn_queue_counter_i (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .up_i    (cnt_up[u]),
      .down_i  (unit_done_any[u]),
      .ready_o (unit_ready[u])
    );
  end

  ////////////////////////////////////////////////////////////
  // Acceptance and issue
  ////////////////////////////////////////////////////////////

  issue_ctrl issue_ctrl_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_unit_i      (req_unit_i),
    .req_vs1_i       (req_vs1_i),
    .req_use_vs1_i   (req_use_vs1_i),
    .req_vs2_i       (req_vs2_i),
    .req_use_vs2_i   (req_use_vs2_i),
    .req_vd_i        (req_vd_i),
    .req_use_vd_i    (req_use_vd_i),
    .req_vm_i        (req_vm_i),
    .req_ready_o     (req_ready_o),
    .hazard_vs1_i    (hz_vs1),
    .hazard_vs2_i    (hz_vs2),
    .hazard_vm_i     (hz_vm),
    .hazard_vd_i     (hz_vd),
    .next_id_i       (next_id),
    .full_i          (full),
    .unit_ready_i    (unit_ready),
    .accept_o        (accept),
    .cnt_up_o        (cnt_up),
    .issue_ready_i   (issue_ready_i),
    .issue_valid_o   (issue_valid_o),
    .issue_id_o      (issue_id_o),
    .issue_unit_o    (issue_unit_o),
    .issue_vs1_o     (issue_vs1_o),
    .issue_use_vs1_o (issue_use_vs1_o),
    .issue_vs2_o     (issue_vs2_o),
    .issue_use_vs2_o (issue_use_vs2_o),
    .issue_vd_o      (issue_vd_o),
    .issue_use_vd_o  (issue_use_vd_o),
    .issue_vm_o      (issue_vm_o),
    .hazard_vs1_o    (hazard_vs1_o),
    .hazard_vs2_o    (hazard_vs2_o),
    .hazard_vm_o     (hazard_vm_o),
    .hazard_vd_o     (hazard_vd_o)
  );

endmodule

`default_nettype wire

//--- verilog/vinsn_tracker.sv
// Instruction tracker keeping the running IDs per unit and handing out the lowest free ID
`timescale 1ns/1ps
`default_nettype none

module vinsn_tracker import seq_pkg::*; (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      alloc_i,
  input  wire unit_t                     alloc_unit_i,
  input  wire vid_mask_t [nr_units-1:0]  unit_done_i,
  output vid_t                           next_id_o,
  output logic                           full_o,
  output vid_mask_t                      running_o,
  output unit_mask_t                     unit_done_any_o,
  output logic                           idle_o
);

  // Running bitmap of each unit
  vid_mask_t [nr_units-1:0] running_q, running_d;

  // Union over all units
  always_comb begin
    running_o = '0;
    for (int u = 0; u < nr_units; u++) begin
      running_o |= running_q[u];
    end
  end

  // Lowest clear bit wins, so scan from the top down
  always_comb begin
    next_id_o = '0;
    for (int i = nr_vinsn - 1; i >= 0; i--) begin
      if (!running_o[i]) next_id_o = vid_t'(i);
    end
  end

  assign full_o = &running_o;
  assign idle_o = ~(|running_o);

  // Completion of anything on a unit drains that unit's queue counter
  always_comb begin
    for (int u = 0; u < nr_units; u++) begin
      unit_done_any_o[u] = |unit_done_i[u];
    end
  end

  // Done clears, allocation sets; an allocated ID is never running, so no overlap
  always_comb begin
    for (int u = 0; u < nr_units; u++) begin
      running_d[u] = running_q[u] & ~unit_done_i[u];
      if (alloc_i && (alloc_unit_i == unit_t'(u))) begin
        running_d[u][next_id_o] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/vreg_scoreboard.sv
// Register scoreboard tracking the last reader and writer of each vector register
`timescale 1ns/1ps
`default_nettype none

module vreg_scoreboard import seq_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      accept_i,
  input  wire vid_t      new_id_i,
  input  wire vid_mask_t running_i,
  input  wire vreg_t     vs1_i,
  input  wire vreg_t     vs2_i,
  input  wire vreg_t     vd_i,
  input  wire logic      use_vs1_i,
  input  wire logic      use_vs2_i,
  input  wire logic      use_vd_i,
  input  wire logic      vm_i,
  output vid_mask_t      hazard_vs1_o,
  output vid_mask_t      hazard_vs2_o,
  output vid_mask_t      hazard_vm_o,
  output vid_mask_t      hazard_vd_o
);

  ////////////////////////////////////////////////////////////
  // Access lists
  ////////////////////////////////////////////////////////////

  // Last reader and last writer ID per register
  vid_t rd_id_q [nr_vregs];
  vid_t wr_id_q [nr_vregs];
  logic [nr_vregs-1:0] rd_valid_q, rd_valid_d;
  logic [nr_vregs-1:0] wr_valid_q, wr_valid_d;

  // Entries whose owner is still running
  logic [nr_vregs-1:0] rd_live, wr_live;

  always_comb begin
    for (int r = 0; r < nr_vregs; r++) begin
      rd_live[r] = rd_valid_q[r] & running_i[rd_id_q[r]];
      wr_live[r] = wr_valid_q[r] & running_i[wr_id_q[r]];
    end
  end

  ////////////////////////////////////////////////////////////
  // Hazard decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vm_o  = '0;
    hazard_vd_o  = '0;
    // RAW on the sources
    if (use_vs1_i && wr_live[vs1_i]) hazard_vs1_o[wr_id_q[vs1_i]] = 1'b1;
    if (use_vs2_i && wr_live[vs2_i]) hazard_vs2_o[wr_id_q[vs2_i]] = 1'b1;
    // vm low means a masked op reading v0
    if (!vm_i && wr_live[vmask_reg]) hazard_vm_o[wr_id_q[vmask_reg]] = 1'b1;
    // WAW and WAR both land on the destination vector
    if (use_vd_i) begin
      if (wr_live[vd_i]) hazard_vd_o[wr_id_q[vd_i]] = 1'b1;
      if (rd_live[vd_i]) hazard_vd_o[rd_id_q[vd_i]] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // List update
  ////////////////////////////////////////////////////////////

  // Dead entries drop out, so a recycled ID never revives a stale one
  always_comb begin
    rd_valid_d = rd_live;
    wr_valid_d = wr_live;
    if (accept_i) begin
      if (use_vd_i)  wr_valid_d[vd_i]      = 1'b1;
      if (use_vs1_i) rd_valid_d[vs1_i]     = 1'b1;
      if (use_vs2_i) rd_valid_d[vs2_i]     = 1'b1;
      if (!vm_i)     rd_valid_d[vmask_reg] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= '0;
      wr_valid_q <= '0;
    end else begin
      rd_valid_q <= rd_valid_d;
      wr_valid_q <= wr_valid_d;
    end
  end

  // Owner ID of each entry, written on accept
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      if (use_vd_i)  wr_id_q[vd_i]      <= new_id_i;
      if (use_vs1_i) rd_id_q[vs1_i]     <= new_id_i;
      if (use_vs2_i) rd_id_q[vs2_i]     <= new_id_i;
      if (!vm_i)     rd_id_q[vmask_reg] <= new_id_i;
    end
  end

endmodule

`default_nettype wire
